// File: design/evrPkg.sv
// Shared constants for the timing-event receiver.
// Holds the special event codes, the strobe count, the timestamp
// widths, the status counter size and the action word width.

`default_nettype none

package evrPkg;

    ////////////////////////////////////////////////////////////////////////////
    // Special event codes

    // Shifts a 0 into the time-of-day seconds register
    localparam logic [7:0] evCodeShiftZero = 8'h70;

    // Shifts a 1 into the time-of-day seconds register
    localparam logic [7:0] evCodeShiftOne = 8'h71;

    // Pulse-per-second marker, applies the assembled seconds value
    localparam logic [7:0] evCodeSecondsMarker = 8'h7D;

    ////////////////////////////////////////////////////////////////////////////
    // Sizes

    // Codes 1 to 126 each get their own strobe
    localparam int evStrobeCount = 126;

    localparam int secondsWidth = 32;
    localparam int ticksWidth = 32;
    localparam int timestampWidth = secondsWidth + ticksWidth;

    // Bit counter of the seconds shift register, it saturates one past full
    localparam int bitCountWidth = 6;
    localparam logic [bitCountWidth-1:0] bitCountFull = bitCountWidth'(secondsWidth);
    localparam logic [bitCountWidth-1:0] bitCountLimit = bitCountWidth'(secondsWidth + 1);

    localparam int statusCounterWidth = 10;

    localparam int actionWidth = 8;

endpackage

`default_nettype wire

// File: design/evrControl.sv
// Link word control block.
// Qualifies each recovered word against its K flags, decodes the
// shift and seconds-marker codes into pulses and registers the
// distributed data byte.

`timescale 1ns/1ps
`default_nettype none

module evrControl
    import evrPkg::*;
(
    input  wire logic       evrRxClk,
    input  wire logic       reset,
    input  wire logic [15:0] evrRxWord,
    input  wire logic [1:0] evrCharIsK,
    output logic      [7:0] evCode,
    output logic            evCodeValid,
    output logic            shiftZero,
    output logic            shiftOne,
    output logic            secondsMark,
    output logic      [7:0] distributedDataBus
);

    ////////////////////////////////////////////////////////////////////////////
    // Word qualification

    // The low byte carries the event code, and a K character there is a
    // comma or other control symbol rather than an event
    assign evCode = evrRxWord[7:0];
    assign evCodeValid = !evrCharIsK[0];

    ////////////////////////////////////////////////////////////////////////////
    // Time-of-day pulses and data byte

    always_ff @(posedge evrRxClk) begin
        if (reset) begin
            shiftZero <= 1'b0;
            shiftOne <= 1'b0;
            secondsMark <= 1'b0;
            distributedDataBus <= 8'h00;
        end else begin
            shiftZero <= evCodeValid && (evCode == evCodeShiftZero);
            shiftOne <= evCodeValid && (evCode == evCodeShiftOne);
            secondsMark <= evCodeValid && (evCode == evCodeSecondsMarker);

            // A K character in the high byte carries no data, so it reads as zero
            if (evrCharIsK[1]) begin
                distributedDataBus <= 8'h00;
            end else begin
                distributedDataBus <= evrRxWord[15:8];
            end
        end
    end

    // The time-of-day receiver relies on seeing a single pulse per cycle
    pulsesExclusive: assert property (
        @(posedge evrRxClk) disable iff (reset)
        $onehot0({shiftZero, shiftOne, secondsMark})
    );

endmodule

`default_nettype wire

// File: design/evStrobeBank.sv
// Per-code event strobe bank.
// One flip-flop per strobed event code plus the seconds marker.

`timescale 1ns/1ps
`default_nettype none

module evStrobeBank
    import evrPkg::*;
(
    input  wire logic                     evrRxClk,
    input  wire logic                     reset,
    input  wire logic [7:0]               evCode,
    input  wire logic                     evCodeValid,
    output logic      [evStrobeCount:1]   evStrobe,
    output logic                          ppsMarker
);

    // Each strobe is high for the single cycle after a valid word with its code
    always_ff @(posedge evrRxClk) begin
        if (reset) begin
            evStrobe <= '0;
            ppsMarker <= 1'b0;
        end else begin
            for (int code = 1; code <= evStrobeCount; code++) begin
                evStrobe[code] <= evCodeValid && (evCode == 8'(code));
            end
            ppsMarker <= evCodeValid && (evCode == evCodeSecondsMarker);
        end
    end

    // Only one code arrives per word
    strobeOneHot: assert property (
        @(posedge evrRxClk) disable iff (reset)
        $onehot0(evStrobe)
    );

endmodule

`default_nettype wire

// File: design/actionTable.sv
// Event code to action word lookup table.
// A 256-entry RAM with a write port, a registered read address
// and a registered, validity-gated output.

`timescale 1ns/1ps
`default_nettype none

module actionTable
    import evrPkg::*;
(
    input  wire logic                   evrRxClk,
    input  wire logic                   reset,
    input  wire logic [7:0]             evCode,
    input  wire logic                   evCodeValid,
    input  wire logic                   actionWriteEnable,
    input  wire logic [7:0]             actionAddress,
    input  wire logic [actionWidth-1:0] actionData,
    output logic      [actionWidth-1:0] action
);

    logic [actionWidth-1:0] actionRam [0:255];
    logic [7:0]             readAddress;
    logic                   readValid;

    ////////////////////////////////////////////////////////////////////////////
    // Table storage

    always_ff @(posedge evrRxClk) begin
        if (actionWriteEnable) begin
            actionRam[actionAddress] <= actionData;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Lookup pipeline

    // Address stage, the RAM is then read from the registered address
    always_ff @(posedge evrRxClk) begin
        if (reset) begin
            readAddress <= '0;
        end else begin
            readAddress <= evCode;
        end
    end

    // Output stage, words that were K characters produce no action
    always_ff @(posedge evrRxClk) begin
        if (reset) begin
            readValid <= 1'b0;
            action <= '0;
        end else begin
            readValid <= evCodeValid;
            action <= readValid ? actionRam[readAddress] : '0;
        end
    end

    writeAddressKnown: assert property (
        @(posedge evrRxClk) disable iff (reset)
        actionWriteEnable |-> !$isunknown(actionAddress)
    );

endmodule

`default_nettype wire

// File: design/todReceiver.sv
// Time-of-day receiver.
// Assembles seconds from shift pulses, applies them at the seconds
// marker, runs the tick counter and keeps the saturating status
// counters for bad bit counts and out-of-sequence seconds.

`timescale 1ns/1ps
`default_nettype none

module todReceiver
    import evrPkg::*;
(
    input  wire logic                          evrRxClk,
    input  wire logic                          reset,
    input  wire logic                          shiftZero,
    input  wire logic                          shiftOne,
    input  wire logic                          secondsMark,
    output logic      [timestampWidth-1:0]     timestamp,
    output logic                               timestampValid,
    output logic      [statusCounterWidth-1:0] tooManyBitsCounter,
    output logic      [statusCounterWidth-1:0] tooFewBitsCounter,
    output logic      [statusCounterWidth-1:0] outOfSeqCounter
);

    logic [secondsWidth-1:0]  shiftReg;
    logic [secondsWidth-1:0]  seconds;
    logic [ticksWidth-1:0]    ticks;
    logic [bitCountWidth-1:0] bitCount;

    // Counts up by one and sticks at all ones
    function automatic logic [statusCounterWidth-1:0] satIncrement(
        input logic [statusCounterWidth-1:0] value
    );
        return (&value) ? value : value + 1'b1;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Seconds assembly and marker handling

    always_ff @(posedge evrRxClk) begin
        if (reset) begin
            shiftReg <= '0;
            seconds <= '0;
            ticks <= '0;
            bitCount <= '0;
            timestampValid <= 1'b0;
            tooManyBitsCounter <= '0;
            tooFewBitsCounter <= '0;
            outOfSeqCounter <= '0;
        end else begin
            ticks <= ticks + 1'b1;

            // Bits arrive MSB first, so each new bit enters at the low end
            if (shiftZero || shiftOne) begin
                shiftReg <= {shiftReg[secondsWidth-2:0], shiftOne};
                if (bitCount != bitCountLimit) begin
                    bitCount <= bitCount + 1'b1;
                end
            end

            // Every marker starts a new second and a new bit sequence
            if (secondsMark) begin
                bitCount <= '0;
                ticks <= '0;

                if (bitCount == bitCountFull) begin
                    seconds <= shiftReg;
                    timestampValid <= 1'b1;
                    if (timestampValid && (shiftReg != seconds + 1'b1)) begin
                        outOfSeqCounter <= satIncrement(outOfSeqCounter);
                    end
                end else begin
                    // Seconds keep their old value but can no longer be trusted
                    timestampValid <= 1'b0;
                    if (bitCount < bitCountFull) begin
                        tooFewBitsCounter <= satIncrement(tooFewBitsCounter);
                    end else begin
                        tooManyBitsCounter <= satIncrement(tooManyBitsCounter);
                    end
                end
            end
        end
    end

    assign timestamp = {seconds, ticks};

    bitCountBounded: assert property (
        @(posedge evrRxClk) disable iff (reset)
        bitCount <= bitCountLimit
    );

endmodule

`default_nettype wire

// File: design/evrTop.sv
// Top level of the timing-event receiver.
// Connects the link word control block to the strobe bank, the
// action table and the time-of-day receiver.

`timescale 1ns/1ps
`default_nettype none

module evrTop
    import evrPkg::*;
(
    input  wire logic                          evrRxClk,
    input  wire logic                          reset,
    input  wire logic [15:0]                   evrRxWord,
    input  wire logic [1:0]                    evrCharIsK,
    input  wire logic                          actionWriteEnable,
    input  wire logic [7:0]                    actionAddress,
    input  wire logic [actionWidth-1:0]        actionData,
    output logic      [evStrobeCount:1]        evStrobe,
    output logic                               ppsMarker,
    output logic      [actionWidth-1:0]        action,
    output logic      [timestampWidth-1:0]     timestamp,
    output logic                               timestampValid,
    output logic      [statusCounterWidth-1:0] tooManyBitsCounter,
    output logic      [statusCounterWidth-1:0] tooFewBitsCounter,
    output logic      [statusCounterWidth-1:0] outOfSeqCounter,
    output logic      [7:0]                    distributedDataBus
);

    logic [7:0] evCode;
    logic       evCodeValid;
    logic       shiftZero;
    logic       shiftOne;
    logic       secondsMark;

    evrControl control_i (
        .evrRxClk(evrRxClk),
        .reset(reset),
        .evrRxWord(evrRxWord),
        .evrCharIsK(evrCharIsK),
        .evCode(evCode),
        .evCodeValid(evCodeValid),
        .shiftZero(shiftZero),
        .shiftOne(shiftOne),
        .secondsMark(secondsMark),
        .distributedDataBus(distributedDataBus)
    );

    evStrobeBank strobeBank_i (
        .evrRxClk(evrRxClk),
        .reset(reset),
        .evCode(evCode),
        .evCodeValid(evCodeValid),
        .evStrobe(evStrobe),
        .ppsMarker(ppsMarker)
    );

    // Lookups see the code combinationally, so the table adds its own two stages
    actionTable actionTable_i (
        .evrRxClk(evrRxClk),
        .reset(reset),
        .evCode(evCode),
        .evCodeValid(evCodeValid),
        .actionWriteEnable(actionWriteEnable),
        .actionAddress(actionAddress),
        .actionData(actionData),
        .action(action)
    );

    todReceiver todReceiver_i (
        .evrRxClk(evrRxClk),
        .reset(reset),
        .shiftZero(shiftZero),
        .shiftOne(shiftOne),
        .secondsMark(secondsMark),
        .timestamp(timestamp),
        .timestampValid(timestampValid),
        .tooManyBitsCounter(tooManyBitsCounter),
        .tooFewBitsCounter(tooFewBitsCounter),
        .outOfSeqCounter(outOfSeqCounter)
    );

endmodule

`default_nettype wire

// File: tests/evrTb.sv
// Directed testbench for the timing-event receiver.
// Covers the reset state, event strobes, action table lookups,
// timestamp loading and the saturating status counters.

`timescale 1ns/1ps
`default_nettype none

module evrTb
    import evrPkg::*;
();

    localparam int clockPeriod = 40;

    // Words sent by each test, used to size the watchdog
    localparam int resetWords = 4;
    localparam int strobeWords = 129;
    localparam int actionWords = 291;
    localparam int timestampWords = 46;
    localparam int counterWords = 213;
    localparam int totalWords = resetWords + strobeWords + actionWords
                                + timestampWords + counterWords;
    localparam int timeoutNs = totalWords * clockPeriod + 4000;

    logic                          evrRxClk;
    logic                          reset;
    logic [15:0]                   evrRxWord;
    logic [1:0]                    evrCharIsK;
    logic                          actionWriteEnable;
    logic [7:0]                    actionAddress;
    logic [actionWidth-1:0]        actionData;
    logic [evStrobeCount:1]        evStrobe;
    logic                          ppsMarker;
    logic [actionWidth-1:0]        action;
    logic [timestampWidth-1:0]     timestamp;
    logic                          timestampValid;
    logic [statusCounterWidth-1:0] tooManyBitsCounter;
    logic [statusCounterWidth-1:0] tooFewBitsCounter;
    logic [statusCounterWidth-1:0] outOfSeqCounter;
    logic [7:0]                    distributedDataBus;

    int          checks = 0;
    int          errors = 0;
    logic [31:0] lfsrState = 32'h9e340637;

    evrTop dut_i (
        .evrRxClk(evrRxClk),
        .reset(reset),
        .evrRxWord(evrRxWord),
        .evrCharIsK(evrCharIsK),
        .actionWriteEnable(actionWriteEnable),
        .actionAddress(actionAddress),
        .actionData(actionData),
        .evStrobe(evStrobe),
        .ppsMarker(ppsMarker),
        .action(action),
        .timestamp(timestamp),
        .timestampValid(timestampValid),
        .tooManyBitsCounter(tooManyBitsCounter),
        .tooFewBitsCounter(tooFewBitsCounter),
        .outOfSeqCounter(outOfSeqCounter),
        .distributedDataBus(distributedDataBus)
    );

    initial begin
        evrRxClk = 1'b0;
        forever #(clockPeriod / 2) evrRxClk = ~evrRxClk;
    end

    initial begin
        #(timeoutNs);
        $display("Timeout: the tests did not finish within %0d ns", timeoutNs);
        $display("*** FAILED ***");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers

    // Galois LFSR, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ 32'h80200003) : (state >> 1);
    endfunction

    task automatic drawBits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsrState = lfsrNext(lfsrState);
            value = {value[30:0], lfsrState[0]};
        end
    endtask

    task automatic reportError(input string message);
        errors++;
        $display("** Error at %0t: %s", $time, message);
    endtask

    // Drives one link word at the rising edge and returns at the falling edge
    task automatic applyWord(input logic [15:0] word, input logic [1:0] charIsK);
        @(posedge evrRxClk);
        evrRxWord <= word;
        evrCharIsK <= charIsK;
        @(negedge evrRxClk);
    endtask

    // Comma characters in both bytes carry neither an event nor data
    task automatic applyIdle();
        applyWord(16'hBCBC, 2'b11);
    endtask

    // Sends the low count bits of value as shift events, MSB first
    task automatic shiftBits(input logic [32:0] value, input int count);
        for (int b = count - 1; b >= 0; b--) begin
            applyWord({8'h00, value[b] ? evCodeShiftOne : evCodeShiftZero}, 2'b00);
        end
    endtask

    // The receiver has applied the marker two cycles after the word
    task automatic sendMarker();
        applyWord({8'h00, evCodeSecondsMarker}, 2'b00);
        repeat (2) applyIdle();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Tests

    task automatic checkReset();
        repeat (2) @(posedge evrRxClk);
        reset <= 1'b0;
        @(negedge evrRxClk);
        checks++;
        if (evStrobe !== '0 || ppsMarker !== 1'b0 || action !== '0
                || timestampValid !== 1'b0) begin
            reportError($sformatf("after reset strobe %h pps %b action %h valid %b",
                                  evStrobe, ppsMarker, action, timestampValid));
        end
        checks++;
        if (tooManyBitsCounter !== '0 || tooFewBitsCounter !== '0
                || outOfSeqCounter !== '0) begin
            reportError($sformatf("after reset counters %h %h %h", tooManyBitsCounter,
                                  tooFewBitsCounter, outOfSeqCounter));
        end
    endtask

    task automatic testEventStrobes();
        logic [7:0]             dataBytes [1:evStrobeCount];
        logic [evStrobeCount:1] expStrobe;
        logic [31:0]            r;
        logic [7:0]             code;
        int                     c;
        for (int i = 1; i <= evStrobeCount; i++) begin
            drawBits(8, r);
            dataBytes[i] = r[7:0];
        end
        // Strobes for a word show up one cycle after it is driven
        for (int i = 0; i < evStrobeCount + 1; i++) begin
            if (i < evStrobeCount) begin
                code = 8'(i + 1);
                applyWord({dataBytes[i + 1], code}, 2'b00);
            end else begin
                applyIdle();
            end
            if (i >= 1) begin
                c = i;
                expStrobe = '0;
                expStrobe[c] = 1'b1;
                checks++;
                if (evStrobe !== expStrobe || ppsMarker !== (c == int'(evCodeSecondsMarker))) begin
                    reportError($sformatf("code %0d gave strobe %h pps %b", c, evStrobe,
                                          ppsMarker));
                end
                checks++;
                if (distributedDataBus !== dataBytes[c]) begin
                    reportError($sformatf("data bus %h, expected %h", distributedDataBus,
                                          dataBytes[c]));
                end
            end
        end

        // K character in the low byte, data byte still valid
        applyWord(16'h5A05, 2'b01);
        applyIdle();
        checks++;
        if (evStrobe !== '0 || ppsMarker !== 1'b0 || distributedDataBus !== 8'h5A) begin
            reportError($sformatf("K word gave strobe %h pps %b data %h", evStrobe,
                                  ppsMarker, distributedDataBus));
        end
    endtask

    task automatic testActionTable();
        logic [actionWidth-1:0] expTable [0:255];
        logic [7:0]             codes [0:31];
        logic [1:0]             kFlags [0:31];
        logic [actionWidth-1:0] expAction [0:31];
        logic [31:0]            r;
        for (int a = 0; a < 256; a++) begin
            drawBits(actionWidth, r);
            expTable[a] = r[actionWidth-1:0];
            @(posedge evrRxClk);
            actionWriteEnable <= 1'b1;
            actionAddress <= 8'(a);
            actionData <= r[actionWidth-1:0];
        end
        @(posedge evrRxClk);
        actionWriteEnable <= 1'b0;
        @(negedge evrRxClk);

        for (int i = 0; i < 32; i++) begin
            drawBits(8, r);
            codes[i] = r[7:0];
            kFlags[i] = (i == 10 || i == 21) ? 2'b01 : 2'b00;
            expAction[i] = kFlags[i][0] ? '0 : expTable[r[7:0]];
        end
        // Back to back lookups, each action two cycles after its word
        for (int i = 0; i < 34; i++) begin
            if (i < 32) begin
                applyWord({8'h00, codes[i]}, kFlags[i]);
            end else begin
                applyIdle();
            end
            if (i >= 2) begin
                checks++;
                if (action !== expAction[i - 2]) begin
                    reportError($sformatf("code %h gave action %h, expected %h",
                                          codes[i - 2], action, expAction[i - 2]));
                end
            end
        end
    endtask

    task automatic testTimestampLoad();
        logic [31:0] value;
        drawBits(secondsWidth, value);
        // Starts a clean bit sequence after the codes of earlier tests
        sendMarker();
        shiftBits({1'b0, value}, secondsWidth);
        sendMarker();
        checks++;
        if (timestamp[timestampWidth-1:ticksWidth] !== value || timestampValid !== 1'b1) begin
            reportError($sformatf("timestamp %h valid %b, expected seconds %h",
                                  timestamp, timestampValid, value));
        end
        for (int j = 0; j < 8; j++) begin
            checks++;
            if (timestamp[ticksWidth-1:0] !== 32'(j)) begin
                reportError($sformatf("ticks %0d, expected %0d", timestamp[ticksWidth-1:0], j));
            end
            applyIdle();
        end
    endtask

    task automatic testStatusCounters();
        logic [statusCounterWidth-1:0] fewBase;
        logic [statusCounterWidth-1:0] manyBase;
        logic [statusCounterWidth-1:0] seqBase;
        logic [31:0]                   value;
        sendMarker();
        fewBase = tooFewBitsCounter;
        manyBase = tooManyBitsCounter;
        seqBase = outOfSeqCounter;
        drawBits(secondsWidth, value);

        shiftBits({1'b0, value}, secondsWidth);
        sendMarker();
        shiftBits({1'b0, value}, secondsWidth - 1);
        sendMarker();
        checks++;
        if (tooFewBitsCounter !== fewBase + 1'b1 || tooManyBitsCounter !== manyBase
                || timestampValid !== 1'b0) begin
            reportError($sformatf("31 bits gave few %0d many %0d valid %b",
                                  tooFewBitsCounter, tooManyBitsCounter, timestampValid));
        end

        shiftBits({1'b1, value}, secondsWidth + 1);
        sendMarker();
        checks++;
        if (tooManyBitsCounter !== manyBase + 1'b1 || tooFewBitsCounter !== fewBase + 1'b1
                || timestampValid !== 1'b0) begin
            reportError($sformatf("33 bits gave few %0d many %0d valid %b",
                                  tooFewBitsCounter, tooManyBitsCounter, timestampValid));
        end

        // The timestamp is invalid here, so the first load is never out of sequence
        shiftBits({1'b0, value}, secondsWidth);
        sendMarker();
        shiftBits({1'b0, value + 32'd5}, secondsWidth);
        sendMarker();
        checks++;
        if (outOfSeqCounter !== seqBase + 1'b1) begin
            reportError($sformatf("jump of 5 gave out of sequence count %0d, expected %0d",
                                  outOfSeqCounter, seqBase + 1'b1));
        end
        shiftBits({1'b0, value + 32'd6}, secondsWidth);
        sendMarker();
        checks++;
        if (outOfSeqCounter !== seqBase + 1'b1 || timestampValid !== 1'b1
                || timestamp[timestampWidth-1:ticksWidth] !== value + 32'd6) begin
            reportError($sformatf("next second gave count %0d valid %b timestamp %h",
                                  outOfSeqCounter, timestampValid, timestamp));
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence

    initial begin
        reset <= 1'b1;
        evrRxWord <= 16'hBCBC;
        evrCharIsK <= 2'b11;
        actionWriteEnable <= 1'b0;
        actionAddress <= '0;
        actionData <= '0;

        checkReset();
        testEventStrobes();
        testActionTable();
        testTimestampLoad();
        testStatusCounters();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
design/evrPkg.sv
design/evrControl.sv
design/evStrobeBank.sv
design/actionTable.sv
design/todReceiver.sv
design/evrTop.sv
tests/evrTb.sv

// File: Makefile
# Verilator build and run for the timing-event receiver testbench

VERILATOR ?= verilator
TOP       ?= evrTb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

PASS_TEXT = *** PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qF '$(PASS_TEXT)' $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
